// File: include/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// integer datapath width
`define XLEN 32

// 32 architectural registers plus the free pool
`define PHYS_REGS 48

// in-flight instructions between rename and retire
`define ROB_DEPTH 8

// holds every physical register that is not mapped at reset
`define FL_DEPTH 16

`endif

// File: verilog/backend_pkg.sv
`include "backend_macros.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [4:0]                    arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;
    typedef logic [$clog2(`ROB_DEPTH):0]   rob_cnt_t;
    typedef logic [$clog2(`FL_DEPTH)-1:0]  fl_idx_t;
    typedef logic [$clog2(`FL_DEPTH):0]    fl_cnt_t;

    // rv32i major opcodes handled by this backend
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

endpackage

// File: verilog/id_stage.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module id_stage
import backend_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      instr_valid_i,
    input  word_t     instr_i,
    input  word_t     instr_pc_i,
    input  logic      rob_full_i,
    input  rob_id_t   alloc_id_i,
    input  logic      free_valid_i,
    input  phys_reg_t free_phys_i,
    output logic      stall_o,
    output logic      ex_valid_o,
    output alu_op_e   ex_alu_op_o,
    output phys_reg_t ex_rs1_phys_o,
    output phys_reg_t ex_rs2_phys_o,
    output phys_reg_t ex_rd_phys_o,
    output word_t     ex_imm_o,
    output logic      ex_use_imm_o,
    output rob_id_t   ex_rob_id_o,
    output logic      alloc_valid_o,
    output word_t     alloc_pc_o,
    output arch_reg_t alloc_rd_arch_o,
    output phys_reg_t alloc_rd_phys_o,
    output phys_reg_t alloc_old_phys_o
);

    arch_reg_t rs1;
    arch_reg_t rs2;
    arch_reg_t rd;
    logic [2:0] funct3;
    alu_op_e   alu_op;
    word_t     imm;
    logic      use_imm;
    logic      accept;
    logic      pop;
    phys_reg_t rd_phys;

    // speculative rename table
    phys_reg_t rat_q [32];

    phys_reg_t fl_q [`FL_DEPTH];
    fl_idx_t   fl_head_q;
    fl_idx_t   fl_tail_q;
    fl_cnt_t   fl_count_q;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];

    always_comb begin
        alu_op  = ALU_ADD;
        imm     = '0;
        use_imm = 1'b0;
        case (rv_opcode_e'(instr_i[6:0]))
            OP: begin
                alu_op = alu_decode(funct3, instr_i[30]);
            end
            OP_IMM: begin
                // bit 30 only selects srai, addi has no subtract form
                alu_op  = alu_decode(funct3, instr_i[30] && (funct3 == 3'b101));
                imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                use_imm = 1'b1;
            end
            LUI: begin
                alu_op  = ALU_PASS_B;
                imm     = {instr_i[31:12], 12'b0};
                use_imm = 1'b1;
            end
            default: ;
        endcase
    end

    assign stall_o = rob_full_i || (fl_count_q == '0);
    assign accept  = instr_valid_i && !stall_o;
    // x0 never takes a register from the pool
    assign pop     = accept && (rd != '0);
    assign rd_phys = (rd != '0) ? fl_q[fl_head_q] : '0;

    assign alloc_valid_o    = accept;
    assign alloc_pc_o       = instr_pc_i;
    assign alloc_rd_arch_o  = rd;
    assign alloc_rd_phys_o  = rd_phys;
    assign alloc_old_phys_o = rat_q[rd];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                rat_q[i] <= phys_reg_t'(i);
            end
        end else if (pop) begin
            rat_q[rd] <= rd_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `FL_DEPTH; i++) begin
                fl_q[i] <= phys_reg_t'(`PHYS_REGS - `FL_DEPTH + i);
            end
            fl_head_q  <= '0;
            fl_tail_q  <= '0;
            fl_count_q <= fl_cnt_t'(`FL_DEPTH);
        end else begin
            if (pop) begin
                fl_head_q <= fl_head_q + 1'b1;
            end
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_phys_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            case ({pop, free_valid_i})
                2'b10:   fl_count_q <= fl_count_q - 1'b1;
                2'b01:   fl_count_q <= fl_count_q + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_alu_op_o   <= alu_op;
            ex_rs1_phys_o <= rat_q[rs1];
            ex_rs2_phys_o <= rat_q[rs2];
            ex_rd_phys_o  <= rd_phys;
            ex_imm_o      <= imm;
            ex_use_imm_o  <= use_imm;
            ex_rob_id_o   <= alloc_id_i;
        end
    end

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module exec_stage
import backend_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      ex_valid_i,
    input  alu_op_e   ex_alu_op_i,
    input  phys_reg_t ex_rs1_phys_i,
    input  phys_reg_t ex_rs2_phys_i,
    input  phys_reg_t ex_rd_phys_i,
    input  word_t     ex_imm_i,
    input  logic      ex_use_imm_i,
    input  rob_id_t   ex_rob_id_i,
    output logic      cdb_valid_o,
    output rob_id_t   cdb_rob_id_o,
    output word_t     cdb_value_o
);

    word_t     prf_q [`PHYS_REGS];
    phys_reg_t cdb_rd_q;
    logic      cdb_wr;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     op_b;
    logic [4:0] shamt;
    word_t     alu_res;

    // the broadcast result lands in the register file at the end of this cycle
    assign cdb_wr = cdb_valid_o && (cdb_rd_q != '0);

    always_comb begin
        rs1_val = (ex_rs1_phys_i == '0) ? '0 : prf_q[ex_rs1_phys_i];
        rs2_val = (ex_rs2_phys_i == '0) ? '0 : prf_q[ex_rs2_phys_i];
        // a producer one cycle ahead is still on the result bus
        if (cdb_wr && (cdb_rd_q == ex_rs1_phys_i)) begin
            rs1_val = cdb_value_o;
        end
        if (cdb_wr && (cdb_rd_q == ex_rs2_phys_i)) begin
            rs2_val = cdb_value_o;
        end
    end

    assign op_b  = ex_use_imm_i ? ex_imm_i : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:    alu_res = rs1_val + op_b;
            ALU_SUB:    alu_res = rs1_val - op_b;
            ALU_AND:    alu_res = rs1_val & op_b;
            ALU_OR:     alu_res = rs1_val | op_b;
            ALU_XOR:    alu_res = rs1_val ^ op_b;
            ALU_SLT:    alu_res = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(rs1_val < op_b);
            ALU_SLL:    alu_res = rs1_val << shamt;
            ALU_SRL:    alu_res = rs1_val >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(rs1_val) >>> shamt);
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            cdb_rob_id_o <= ex_rob_id_i;
            cdb_rd_q     <= ex_rd_phys_i;
            // writes to x0 report zero at retire
            cdb_value_o  <= (ex_rd_phys_i == '0) ? '0 : alu_res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                prf_q[i] <= '0;
            end
        end else if (cdb_wr) begin
            prf_q[cdb_rd_q] <= cdb_value_o;
        end
    end

endmodule

// File: verilog/rob.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module rob
import backend_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      retire_ready_i,
    input  logic      alloc_valid_i,
    input  word_t     alloc_pc_i,
    input  arch_reg_t alloc_rd_arch_i,
    input  phys_reg_t alloc_rd_phys_i,
    input  phys_reg_t alloc_old_phys_i,
    input  logic      cdb_valid_i,
    input  rob_id_t   cdb_rob_id_i,
    input  word_t     cdb_value_i,
    output logic      rob_full_o,
    output rob_id_t   alloc_id_o,
    output logic      free_valid_o,
    output phys_reg_t free_phys_o,
    output logic      retire_valid_o,
    output word_t     retire_pc_o,
    output arch_reg_t retire_rd_o,
    output word_t     retire_value_o
);

    word_t     pc_q       [`ROB_DEPTH];
    arch_reg_t rd_arch_q  [`ROB_DEPTH];
    phys_reg_t rd_phys_q  [`ROB_DEPTH];
    phys_reg_t old_phys_q [`ROB_DEPTH];
    word_t     value_q    [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;

    // committed mapping per architectural register
    phys_reg_t rrat_q [32];

    rob_id_t  head_q;
    rob_id_t  tail_q;
    rob_cnt_t count_q;
    logic     do_retire;

    assign rob_full_o     = (count_q == rob_cnt_t'(`ROB_DEPTH));
    assign alloc_id_o     = tail_q;
    assign retire_valid_o = (count_q != '0) && done_q[head_q];
    assign retire_pc_o    = pc_q[head_q];
    assign retire_rd_o    = rd_arch_q[head_q];
    assign retire_value_o = value_q[head_q];
    assign do_retire      = retire_valid_o && retire_ready_i;

    // phys 0 only ever backs x0, so a zero old mapping stays out of the pool
    assign free_valid_o = do_retire && (old_phys_q[head_q] != '0);
    assign free_phys_o  = rrat_q[rd_arch_q[head_q]];

    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            pc_q[tail_q]       <= alloc_pc_i;
            rd_arch_q[tail_q]  <= alloc_rd_arch_i;
            rd_phys_q[tail_q]  <= alloc_rd_phys_i;
            old_phys_q[tail_q] <= alloc_old_phys_i;
        end
        if (cdb_valid_i) begin
            value_q[cdb_rob_id_i] <= cdb_value_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_valid_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_valid_i) begin
                done_q[cdb_rob_id_i] <= 1'b1;
            end
            if (do_retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_valid_i, do_retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                rrat_q[i] <= phys_reg_t'(i);
            end
        end else if (do_retire && (rd_arch_q[head_q] != '0)) begin
            rrat_q[rd_arch_q[head_q]] <= rd_phys_q[head_q];
        end
    end

endmodule

// File: verilog/backend_top.sv
`timescale 1ns/1ps

module backend_top
import backend_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      instr_valid_i,
    input  word_t     instr_i,
    input  word_t     instr_pc_i,
    output logic      stall_o,
    input  logic      retire_ready_i,
    output logic      retire_valid_o,
    output word_t     retire_pc_o,
    output arch_reg_t retire_rd_o,
    output word_t     retire_value_o
);

    // decode to execute
    logic      ex_valid;
    alu_op_e   ex_alu_op;
    phys_reg_t ex_rs1_phys;
    phys_reg_t ex_rs2_phys;
    phys_reg_t ex_rd_phys;
    word_t     ex_imm;
    logic      ex_use_imm;
    rob_id_t   ex_rob_id;

    // rob allocation
    logic      alloc_valid;
    word_t     alloc_pc;
    arch_reg_t alloc_rd_arch;
    phys_reg_t alloc_rd_phys;
    phys_reg_t alloc_old_phys;
    logic      rob_full;
    rob_id_t   alloc_id;

    // result bus
    logic      cdb_valid;
    rob_id_t   cdb_rob_id;
    word_t     cdb_value;

    logic      free_valid;
    phys_reg_t free_phys;

    id_stage id_stage_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .instr_pc_i       (instr_pc_i),
        .rob_full_i       (rob_full),
        .alloc_id_i       (alloc_id),
        .free_valid_i     (free_valid),
        .free_phys_i      (free_phys),
        .stall_o          (stall_o),
        .ex_valid_o       (ex_valid),
        .ex_alu_op_o      (ex_alu_op),
        .ex_rs1_phys_o    (ex_rs1_phys),
        .ex_rs2_phys_o    (ex_rs2_phys),
        .ex_rd_phys_o     (ex_rd_phys),
        .ex_imm_o         (ex_imm),
        .ex_use_imm_o     (ex_use_imm),
        .ex_rob_id_o      (ex_rob_id),
        .alloc_valid_o    (alloc_valid),
        .alloc_pc_o       (alloc_pc),
        .alloc_rd_arch_o  (alloc_rd_arch),
        .alloc_rd_phys_o  (alloc_rd_phys),
        .alloc_old_phys_o (alloc_old_phys)
    );

    exec_stage exec_stage_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_valid_i    (ex_valid),
        .ex_alu_op_i   (ex_alu_op),
        .ex_rs1_phys_i (ex_rs1_phys),
        .ex_rs2_phys_i (ex_rs2_phys),
        .ex_rd_phys_i  (ex_rd_phys),
        .ex_imm_i      (ex_imm),
        .ex_use_imm_i  (ex_use_imm),
        .ex_rob_id_i   (ex_rob_id),
        .cdb_valid_o   (cdb_valid),
        .cdb_rob_id_o  (cdb_rob_id),
        .cdb_value_o   (cdb_value)
    );

    rob rob_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .retire_ready_i   (retire_ready_i),
        .alloc_valid_i    (alloc_valid),
        .alloc_pc_i       (alloc_pc),
        .alloc_rd_arch_i  (alloc_rd_arch),
        .alloc_rd_phys_i  (alloc_rd_phys),
        .alloc_old_phys_i (alloc_old_phys),
        .cdb_valid_i      (cdb_valid),
        .cdb_rob_id_i     (cdb_rob_id),
        .cdb_value_i      (cdb_value),
        .rob_full_o       (rob_full),
        .alloc_id_o       (alloc_id),
        .free_valid_o     (free_valid),
        .free_phys_o      (free_phys),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_value_o   (retire_value_o)
    );

endmodule

// File: testbench/backend_asserts.sv
`timescale 1ns/1ps

module backend_asserts (
    input logic        clk,
    input logic        reset_i,
    input logic        stall_i,
    input logic        retire_ready_i,
    input logic        retire_valid_i,
    input logic [31:0] retire_pc_i,
    input logic [4:0]  retire_rd_i,
    input logic [31:0] retire_value_i,
    input logic        rob_full_i
);

    // nothing is presented for retire right after a reset edge
    assert property (@(posedge clk) reset_i |=> !retire_valid_i)
        else $error("retire valid seen during reset");

    // head entry is held while the consumer is not ready
    assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_i && !retire_ready_i |=>
            retire_valid_i && $stable(retire_pc_i) && $stable(retire_rd_i) &&
            $stable(retire_value_i))
        else $error("retire outputs changed under back-pressure");

    // a stall only clears through a retire
    assert property (@(posedge clk) disable iff (reset_i)
        stall_i && !(retire_valid_i && retire_ready_i) |=> stall_i)
        else $error("instruction accepted while stalled");

    // a full buffer without a retire takes no new entry
    assert property (@(posedge clk) disable iff (reset_i)
        rob_full_i && !(retire_valid_i && retire_ready_i) |=> rob_full_i)
        else $error("reorder buffer written while full");

endmodule

bind backend_top backend_asserts asserts_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .stall_i        (stall_o),
    .retire_ready_i (retire_ready_i),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o),
    .retire_rd_i    (retire_rd_o),
    .retire_value_i (retire_value_o),
    .rob_full_i     (rob_full)
);

// File: testbench/backend_tb.sv
`timescale 1ns/1ps
`include "backend_macros.svh"

module backend_tb
import backend_pkg::*;
();

    localparam int FIELDS    = 6;
    localparam int MAX_LINES = 64;

    logic      clk;
    logic      reset_i;
    logic      instr_valid_i;
    word_t     instr_i;
    word_t     instr_pc_i;
    logic      stall_o;
    logic      retire_ready_i;
    logic      retire_valid_o;
    word_t     retire_pc_o;
    arch_reg_t retire_rd_o;
    word_t     retire_value_o;

    // per line: test, instruction, pc, ready level, expected rd, expected value
    logic [31:0] pat [0:FIELDS*MAX_LINES-1];

    word_t     exp_pc_q  [$];
    arch_reg_t exp_rd_q  [$];
    word_t     exp_val_q [$];

    int     num_lines;
    int     err_count;
    int     test_count;
    int     retire_count;
    int     cycles;
    int     cycle_limit;
    int     stall_run;
    integer seed;
    integer rnd;
    logic   ready_level;
    logic   random_en;

    backend_top UUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_pc_i     (instr_pc_i),
        .stall_o        (stall_o),
        .retire_ready_i (retire_ready_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_value_o (retire_value_o)
    );

    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input arch_reg_t exp, input arch_reg_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            err_count++;
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (random_en) begin
            rnd = $random(seed);
            retire_ready_i = rnd[0];
        end else begin
            retire_ready_i = ready_level;
        end
    end

    // retire is decided at the next rising edge, inputs are stable here
    always @(negedge clk) begin
        if (!reset_i && retire_valid_o && retire_ready_i) begin
            if (exp_pc_q.size() == 0) begin
                $display("retire with no instruction outstanding at pc %h", retire_pc_o);
                err_count++;
            end else begin
                check_word("retire_pc_o", exp_pc_q.pop_front(), retire_pc_o);
                check_reg("retire_rd_o", exp_rd_q.pop_front(), retire_rd_o);
                check_word("retire_value_o", exp_val_q.pop_front(), retire_value_o);
                retire_count++;
            end
        end
    end

    // with ready held high a stall must clear within the retire latency
    always @(negedge clk) begin
        if (!reset_i && !random_en && ready_level && stall_o) begin
            stall_run++;
            if (stall_run == 5) begin
                $display("stall held longer than the retire latency");
                err_count++;
            end
        end else begin
            stall_run = 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("backend hung after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic run_test(input int first, input int last);
        int idx;
        int accepted;
        int errs_before;
        int tnum;
        logic mode;
        idx         = first;
        accepted    = 0;
        errs_before = err_count;
        tnum        = pat[first*FIELDS];
        mode        = pat[first*FIELDS+3][0];
        ready_level = mode;
        while (idx < last) begin
            @(posedge clk);
            #1;
            instr_valid_i = 1'b1;
            instr_i       = pat[idx*FIELDS+1];
            instr_pc_i    = pat[idx*FIELDS+2];
            @(negedge clk);
            if (!stall_o) begin
                exp_pc_q.push_back(pat[idx*FIELDS+2]);
                exp_rd_q.push_back(pat[idx*FIELDS+4][4:0]);
                exp_val_q.push_back(pat[idx*FIELDS+5]);
                idx++;
                accepted++;
                if (!mode && accepted == `ROB_DEPTH) begin
                    @(posedge clk);
                    #1;
                    instr_valid_i = 1'b0;
                    @(negedge clk);
                    if (!stall_o) begin
                        $display("stall did not rise after %0d accepts", accepted);
                        err_count++;
                    end
                    random_en = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        while (exp_pc_q.size() != 0) begin
            @(posedge clk);
        end
        random_en   = 1'b0;
        ready_level = 1'b1;
        test_count++;
        $display("test %0d: %0d instructions, %s", tnum, last - first,
                 (err_count == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int idx;
        int last;
        clk            = 1'b0;
        reset_i        = 1'b1;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        instr_pc_i     = '0;
        retire_ready_i = 1'b0;
        ready_level    = 1'b0;
        random_en      = 1'b0;
        seed           = 24881;
        err_count      = 0;
        test_count     = 0;
        retire_count   = 0;
        cycles         = 0;
        stall_run      = 0;
        cycle_limit    = 1000;
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            pat[i] = '1;
        end
        $readmemh("testbench/backend_patterns.txt", pat);
        num_lines = 0;
        while (num_lines < MAX_LINES && pat[num_lines*FIELDS] != '1) begin
            num_lines++;
        end
        cycle_limit = num_lines * 4 + 50;
        if (num_lines == 0) begin
            $display("pattern file is empty or missing");
            err_count++;
        end

        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;

        idx = 0;
        while (idx < num_lines) begin
            last = idx;
            while (last < num_lines && pat[last*FIELDS] == pat[idx*FIELDS]) begin
                last++;
            end
            run_test(idx, last);
            idx = last;
        end

        $display("tests %0d, retires %0d, errors %0d", test_count, retire_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: testbench/backend_patterns.txt
// test instr pc ready rd value, one instruction per line, all hex
// ready 1 holds retire ready high, 0 holds it low until the buffer fills
1 06400093 00001000 1 01 00000064
1 FF900113 00001004 1 02 FFFFFFF9
1 123451B7 00001008 1 03 12345000
1 00208233 0000100C 1 04 0000005D
1 402082B3 00001010 1 05 0000006B
1 0020F333 00001014 1 06 00000060
1 0020E3B3 00001018 1 07 FFFFFFFD
1 0020C433 0000101C 1 08 FFFFFF9D
1 001124B3 00001020 1 09 00000001
1 00113533 00001024 1 0A 00000000
1 00409593 00001028 1 0B 00000640
1 01C15613 0000102C 1 0C 0000000F
1 40115693 00001030 1 0D FFFFFFFC
1 00409733 00001034 1 0E 80000000
1 404157B3 00001038 1 0F FFFFFFFF
1 0AB1E813 0000103C 1 10 123450AB
1 FFF0C893 00001040 1 11 FFFFFF9B
1 FFA12913 00001044 1 12 00000001
1 FFF0B993 00001048 1 13 00000001
1 0F017A13 0000104C 1 14 000000F0
2 00500A93 00001050 1 15 00000005
2 015A8AB3 00001054 1 15 0000000A
2 015A8AB3 00001058 1 15 00000014
2 FFDA8A93 0000105C 1 15 00000011
2 401A8B33 00001060 1 16 FFFFFFAD
2 002B1B13 00001064 1 16 FFFFFEB4
3 00508013 00001068 1 00 00000000
3 00100B93 0000106C 1 17 00000001
3 00208033 00001070 1 00 00000000
3 001B8C13 00001074 1 18 00000002
4 001C8C93 00001078 0 19 00000001
4 001C8C93 0000107C 0 19 00000002
4 001C8C93 00001080 0 19 00000003
4 001C8C93 00001084 0 19 00000004
4 001C8C93 00001088 0 19 00000005
4 001C8C93 0000108C 0 19 00000006
4 001C8C93 00001090 0 19 00000007
4 001C8C93 00001094 0 19 00000008
4 001C8C93 00001098 0 19 00000009
4 001C8C93 0000109C 0 19 0000000A
5 003D0D13 000010A0 1 1A 00000003
5 003D0D13 000010A4 1 1A 00000006
5 003D0D13 000010A8 1 1A 00000009
5 003D0D13 000010AC 1 1A 0000000C
5 003D0D13 000010B0 1 1A 0000000F
5 003D0D13 000010B4 1 1A 00000012
5 003D0D13 000010B8 1 1A 00000015
5 003D0D13 000010BC 1 1A 00000018
5 003D0D13 000010C0 1 1A 0000001B
5 003D0D13 000010C4 1 1A 0000001E
5 003D0D13 000010C8 1 1A 00000021
5 003D0D13 000010CC 1 1A 00000024
5 003D0D13 000010D0 1 1A 00000027
5 003D0D13 000010D4 1 1A 0000002A
5 003D0D13 000010D8 1 1A 0000002D
5 003D0D13 000010DC 1 1A 00000030
5 003D0D13 000010E0 1 1A 00000033

// File: filelist.f
+incdir+include
verilog/backend_pkg.sv
verilog/id_stage.sv
verilog/exec_stage.sv
verilog/rob.sv
verilog/backend_top.sv
testbench/backend_asserts.sv
testbench/backend_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= backend_tb
RTL_TOP    ?= backend_top
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= No errors
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
